// File: fir_pkg.sv
// shared FIR types and register map; all words are 32 bits, addresses 12 bits
`default_nettype none

package fir_pkg;

  typedef logic [11:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] coef_t;
  typedef logic [31:0] sample_t;

  // AXI-Lite register map
  localparam addr_t ADDR_AP_CTRL  = 12'h000;
  localparam addr_t ADDR_DATA_LEN = 12'h010;
  localparam addr_t ADDR_COEF_LEN = 12'h014;
  localparam addr_t ADDR_TAP_BASE = 12'h040;

  // ap_ctrl read values
  localparam logic [2:0] AP_IDLE  = 3'b100;
  localparam logic [2:0] AP_START = 3'b001;
  localparam logic [2:0] AP_DONE  = 3'b010;

  // tap reads while a run is active
  localparam data_t READ_BUSY = 32'hffff_ffff;

  // single-cycle register write from the bus slave
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t data;
  } lite_wr_t;

  // run configuration, stable while the filter runs
  typedef struct packed {
    data_t data_length;
    data_t coef_length;
  } cfg_t;

endpackage

`default_nettype wire

// File: fir_ram.sv
// single-port RAM with registered read-first output; no reset, contents unknown until written
`default_nettype none
`timescale 1ns/1ns

module fir_ram #(
  parameter int  depth  = 11,
  parameter type word_t = logic [31:0]
) (
  input  wire                       axis_clk,
  input  wire                       we,
  input  wire [$clog2(depth)-1:0]   addr,
  input  wire word_t                wdata,
  output word_t                     rdata
);

  word_t mem [depth];

  // old contents come out when reading the address being written
  always_ff @(posedge axis_clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: fir_axil_slave.sv
// AXI-Lite slave, one write and one read outstanding; master must hold addr/data until ready
`default_nettype none
`timescale 1ns/1ns

module fir_axil_slave (
  input  wire                  axis_clk,
  input  wire                  axis_rst_n,
  input  wire                  awvalid,
  input  wire fir_pkg::addr_t  awaddr,
  input  wire                  wvalid,
  input  wire fir_pkg::data_t  wdata,
  output logic                 awready,
  output logic                 wready,
  input  wire                  arvalid,
  input  wire fir_pkg::addr_t  araddr,
  output logic                 arready,
  output logic                 rvalid,
  input  wire                  rready,
  output fir_pkg::data_t       rdata,
  output fir_pkg::lite_wr_t    lite_wr,
  output logic                 rd_req,
  output fir_pkg::addr_t       rd_addr,
  input  wire fir_pkg::data_t  rd_data
);

  typedef enum logic [1:0] {R_IDLE, R_WAIT, R_VALID} rd_state_t;

  rd_state_t rd_state;
  logic      wr_acc;

  // take the write once address and data are both on the bus
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      wr_acc <= 1'b0;
    end else begin
      wr_acc <= awvalid && wvalid && !wr_acc;
    end
  end

  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign lite_wr = '{wr: wr_acc, addr: awaddr, data: wdata};

  // read: address phase, one cycle for register data, then hold until rready
  assign arready = (rd_state == R_IDLE) && arvalid;
  assign rd_req  = arready;
  assign rd_addr = araddr;
  assign rvalid  = (rd_state == R_VALID);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: begin
          if (arvalid) begin
            rd_state <= R_WAIT;
          end
        end
        R_WAIT: begin
          rd_state <= R_VALID;
        end
        R_VALID: begin
          if (rready) begin
            rd_state <= R_IDLE;
          end
        end
        default: begin
          rd_state <= R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge axis_clk) begin
    if (rd_state == R_WAIT) begin
      rdata <= rd_data;
    end
  end

  // both channels are taken together, and only while the master still offers them
  a_write_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    awready |-> (wready && awvalid && wvalid));

endmodule

`default_nettype wire

// File: fir_regs.sv
// FIR config and run control; a tap read in the same cycle as a bus write returns wrong data
`default_nettype none
`timescale 1ns/1ns

module fir_regs #(
  parameter int tap_num = 11
) (
  input  wire                        axis_clk,
  input  wire                        axis_rst_n,
  input  wire fir_pkg::lite_wr_t     lite_wr,
  input  wire                        rd_req,
  input  wire fir_pkg::addr_t        rd_addr,
  output fir_pkg::data_t             rd_data,
  output fir_pkg::cfg_t              cfg,
  output logic                       run_start,
  input  wire                        run_done,
  input  wire [$clog2(tap_num)-1:0]  tap_addr,
  output fir_pkg::coef_t             tap_coef
);

  localparam int idx_w = $clog2(tap_num);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} run_state_t;

  run_state_t       state;
  logic [2:0]       ap_code;
  logic             idle;
  logic             wr_tap;
  logic             rd_tap;
  logic             rd_tap_q;
  logic [idx_w-1:0] ram_addr;
  fir_pkg::data_t   reg_word;

  function automatic logic tap_hit(input fir_pkg::addr_t a);
    return (a >= fir_pkg::ADDR_TAP_BASE) &&
           (a < fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * tap_num));
  endfunction

  function automatic logic [idx_w-1:0] tap_index(input fir_pkg::addr_t a);
    fir_pkg::addr_t off;
    off = a - fir_pkg::ADDR_TAP_BASE;
    return off[idx_w+1:2];
  endfunction

  always_comb begin
    case (state)
      ST_RUN:  ap_code = fir_pkg::AP_START;
      ST_DONE: ap_code = fir_pkg::AP_DONE;
      default: ap_code = fir_pkg::AP_IDLE;
    endcase
  end

  assign idle      = (state == ST_IDLE);
  assign run_start = idle && lite_wr.wr && (lite_wr.addr == fir_pkg::ADDR_AP_CTRL) &&
                     lite_wr.data[0];
  assign wr_tap    = idle && lite_wr.wr && tap_hit(lite_wr.addr);
  assign rd_tap    = idle && tap_hit(rd_addr);

  // engine owns the tap memory during a run
  assign ram_addr = !idle      ? tap_addr :
                    lite_wr.wr ? tap_index(lite_wr.addr) : tap_index(rd_addr);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= ST_IDLE;
      cfg   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (run_start) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (run_done) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          // reading done back acknowledges it
          if (rd_req && (rd_addr == fir_pkg::ADDR_AP_CTRL)) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
      if (idle && lite_wr.wr) begin
        if (lite_wr.addr == fir_pkg::ADDR_DATA_LEN) begin
          cfg.data_length <= lite_wr.data;
        end
        if (lite_wr.addr == fir_pkg::ADDR_COEF_LEN) begin
          cfg.coef_length <= lite_wr.data;
        end
      end
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rd_tap_q <= 1'b0;
    end else if (rd_req) begin
      rd_tap_q <= rd_tap;
    end
  end

  // ap_ctrl is captured at the strobe, before done falls back to idle
  always_ff @(posedge axis_clk) begin
    if (rd_req) begin
      case (rd_addr)
        fir_pkg::ADDR_AP_CTRL:  reg_word <= fir_pkg::data_t'(ap_code);
        fir_pkg::ADDR_DATA_LEN: reg_word <= cfg.data_length;
        fir_pkg::ADDR_COEF_LEN: reg_word <= cfg.coef_length;
        default:                reg_word <= tap_hit(rd_addr) ? fir_pkg::READ_BUSY : '0;
      endcase
    end
  end

  fir_ram #(
    .depth  (tap_num),
    .word_t (fir_pkg::coef_t)
  ) u_tap_ram (
    .axis_clk (axis_clk),
    .we       (wr_tap),
    .addr     (ram_addr),
    .wdata    (fir_pkg::coef_t'(lite_wr.data)),
    .rdata    (tap_coef)
  );

  assign rd_data = rd_tap_q ? fir_pkg::data_t'(tap_coef) : reg_word;

  // the engine only finishes a run that was started here
  a_done_in_run: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    run_done |-> (state == ST_RUN));

endmodule

`default_nettype wire

// File: fir_engine.sv
// serial MAC FIR engine; needs tap_num >= 2, 1 <= coef_length <= tap_num, data_length >= 1
`default_nettype none
`timescale 1ns/1ns

module fir_engine #(
  parameter int tap_num = 11
) (
  input  wire                        axis_clk,
  input  wire                        axis_rst_n,
  input  wire fir_pkg::cfg_t         cfg,
  input  wire                        run_start,
  output logic                       run_done,
  output logic [$clog2(tap_num)-1:0] tap_addr,
  input  wire fir_pkg::coef_t        tap_coef,
  input  wire                        ss_tvalid,
  input  wire                        ss_tlast,
  input  wire fir_pkg::sample_t      ss_tdata,
  output logic                       ss_tready,
  input  wire                        sm_tready,
  output logic                       sm_tvalid,
  output logic                       sm_tlast,
  output fir_pkg::sample_t           sm_tdata
);

  localparam int idx_w = $clog2(tap_num);

  typedef logic [idx_w-1:0] idx_t;
  typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_WAIT, S_WRITE, S_ACC, S_HOLD} eng_state_t;

  eng_state_t       state;
  idx_t             clr_cnt;
  idx_t             wr_ptr;
  idx_t             rd_ptr;
  idx_t             tap_idx;
  idx_t             len_m1;
  idx_t             ram_addr;
  logic             ram_we;
  fir_pkg::sample_t ram_wdata;
  fir_pkg::sample_t x_q;
  fir_pkg::sample_t x_rd;
  fir_pkg::sample_t prod;
  fir_pkg::sample_t acc;
  fir_pkg::data_t   out_cnt;
  logic             issue_v;
  logic             issue_last;
  logic             rd_v;
  logic             rd_last;
  logic             prod_v;
  logic             prod_last;
  logic             tlast_seen;
  logic             in_beat;
  logic             out_beat;

  assign len_m1     = idx_t'(cfg.coef_length - 32'd1);
  assign issue_v    = (state == S_ACC);
  assign issue_last = issue_v && (tap_idx == len_m1);
  assign in_beat    = ss_tvalid && ss_tready;
  assign out_beat   = sm_tvalid && sm_tready;
  assign ss_tready  = (state == S_WAIT) && !tlast_seen;
  assign sm_tlast   = (out_cnt == cfg.data_length - 32'd1);
  assign run_done   = out_beat && sm_tlast;
  assign tap_addr   = tap_idx;

  assign ram_we    = (state == S_CLEAR) || (state == S_WRITE);
  assign ram_wdata = (state == S_CLEAR) ? '0 : x_q;
  assign ram_addr  = (state == S_CLEAR) ? clr_cnt :
                     (state == S_WRITE) ? wr_ptr : rd_ptr;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state   <= S_IDLE;
      clr_cnt <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      tap_idx <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (run_start) begin
            state   <= S_CLEAR;
            clr_cnt <= '0;
            wr_ptr  <= '0;
          end
        end
        S_CLEAR: begin
          // wipe the whole history, one entry per cycle
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_cnt == idx_t'(tap_num - 1)) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (in_beat) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          rd_ptr  <= wr_ptr;
          tap_idx <= '0;
          wr_ptr  <= (wr_ptr == len_m1) ? '0 : wr_ptr + 1'b1;
          state   <= S_ACC;
        end
        S_ACC: begin
          // newest sample pairs with tap 0, walking back in time
          rd_ptr  <= (rd_ptr == '0) ? len_m1 : rd_ptr - 1'b1;
          tap_idx <= tap_idx + 1'b1;
          if (issue_last) begin
            state <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (out_beat) begin
            state <= sm_tlast ? S_IDLE : S_WAIT;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // memory read, product and accumulate stages
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rd_v       <= 1'b0;
      rd_last    <= 1'b0;
      prod_v     <= 1'b0;
      prod_last  <= 1'b0;
      sm_tvalid  <= 1'b0;
      out_cnt    <= '0;
      tlast_seen <= 1'b0;
    end else begin
      rd_v      <= issue_v;
      rd_last   <= issue_last;
      prod_v    <= rd_v;
      prod_last <= rd_last;
      if (prod_last) begin
        sm_tvalid <= 1'b1;
      end else if (out_beat) begin
        sm_tvalid <= 1'b0;
      end
      if (run_start) begin
        out_cnt <= '0;
      end else if (out_beat) begin
        out_cnt <= out_cnt + 32'd1;
      end
      if (run_start) begin
        tlast_seen <= 1'b0;
      end else if (in_beat && ss_tlast) begin
        tlast_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (in_beat) begin
      x_q <= ss_tdata;
    end
    prod <= fir_pkg::sample_t'(x_rd * tap_coef);
    if (state == S_WRITE) begin
      acc <= '0;
    end else if (prod_v) begin
      acc <= acc + prod;
    end
    if (prod_last) begin
      sm_tdata <= acc + prod;
    end
  end

  fir_ram #(
    .depth  (tap_num),
    .word_t (fir_pkg::sample_t)
  ) u_sample_ram (
    .axis_clk (axis_clk),
    .we       (ram_we),
    .addr     (ram_addr),
    .wdata    (ram_wdata),
    .rdata    (x_rd)
  );

  a_out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata)));

  // one sample in flight at a time
  a_one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ss_tready && sm_tvalid));

endmodule

`default_nettype wire

// File: fir.sv
// FIR top with AXI-Lite config and AXI-Stream data; tap_num >= 2 sets both memory depths
`default_nettype none
`timescale 1ns/1ns

module fir #(
  parameter int tap_num = 11
) (
  output logic                  awready,
  output logic                  wready,
  input  wire                   awvalid,
  input  wire fir_pkg::addr_t   awaddr,
  input  wire                   wvalid,
  input  wire fir_pkg::data_t   wdata,
  output logic                  arready,
  input  wire                   rready,
  input  wire                   arvalid,
  input  wire fir_pkg::addr_t   araddr,
  output logic                  rvalid,
  output fir_pkg::data_t        rdata,
  input  wire                   ss_tvalid,
  input  wire fir_pkg::sample_t ss_tdata,
  input  wire                   ss_tlast,
  output logic                  ss_tready,
  input  wire                   sm_tready,
  output logic                  sm_tvalid,
  output fir_pkg::sample_t      sm_tdata,
  output logic                  sm_tlast,
  input  wire                   axis_clk,
  input  wire                   axis_rst_n
);

  fir_pkg::lite_wr_t          lite_wr;
  logic                       rd_req;
  fir_pkg::addr_t             rd_addr;
  fir_pkg::data_t             rd_data;
  fir_pkg::cfg_t              cfg;
  logic                       run_start;
  logic                       run_done;
  logic [$clog2(tap_num)-1:0] tap_addr;
  fir_pkg::coef_t             tap_coef;

  fir_axil_slave u_axil (
    .axis_clk, .axis_rst_n,
    .awvalid, .awaddr, .wvalid, .wdata, .awready, .wready,
    .arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
    .lite_wr, .rd_req, .rd_addr, .rd_data
  );

  fir_regs #(.tap_num(tap_num)) u_regs (
    .axis_clk, .axis_rst_n,
    .lite_wr, .rd_req, .rd_addr, .rd_data,
    .cfg, .run_start, .run_done, .tap_addr, .tap_coef
  );

  fir_engine #(.tap_num(tap_num)) u_engine (
    .axis_clk, .axis_rst_n,
    .cfg, .run_start, .run_done, .tap_addr, .tap_coef,
    .ss_tvalid, .ss_tlast, .ss_tdata, .ss_tready,
    .sm_tready, .sm_tvalid, .sm_tlast, .sm_tdata
  );

endmodule

`default_nettype wire

// File: tb_fir.sv
// self-checking testbench for fir with tap_num 11; three runs from a fixed xorshift seed
`default_nettype none
`timescale 1ns/1ns

module tb_fir;

  localparam int tap_num  = 11;
  localparam int num_runs = 3;
  localparam int max_dlen = 40;
  // three runs of at most 40 samples, margin of ten for gaps, stalls and bus traffic
  localparam int max_cycles = num_runs * max_dlen * (tap_num + 4) * 10 + 2000;

  logic             axis_clk;
  logic             axis_rst_n;
  logic             awvalid;
  logic             wvalid;
  logic             arvalid;
  logic             rready;
  logic             awready;
  logic             wready;
  logic             arready;
  logic             rvalid;
  fir_pkg::addr_t   awaddr;
  fir_pkg::addr_t   araddr;
  fir_pkg::data_t   wdata;
  fir_pkg::data_t   rdata;
  logic             ss_tvalid;
  logic             ss_tlast;
  logic             ss_tready;
  fir_pkg::sample_t ss_tdata;
  logic             sm_tready;
  logic             sm_tvalid;
  logic             sm_tlast;
  fir_pkg::sample_t sm_tdata;

  logic [31:0]      seed;
  int               data_errs;
  int               sample_errs;
  int               flag_errs;
  int               cycles;
  int               clen;
  int               dlen;
  int               prev_clen;
  fir_pkg::coef_t   taps [tap_num];
  fir_pkg::sample_t xs [max_dlen];

  fir #(.tap_num(tap_num)) u_fir (
    .awready, .wready, .awvalid, .awaddr, .wvalid, .wdata,
    .arready, .rready, .arvalid, .araddr, .rvalid, .rdata,
    .ss_tvalid, .ss_tdata, .ss_tlast, .ss_tready,
    .sm_tready, .sm_tvalid, .sm_tdata, .sm_tlast,
    .axis_clk, .axis_rst_n
  );

  initial axis_clk = 1'b0;
  always #4 axis_clk = ~axis_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_word();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_word();
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  // y[n] = sum of h[k] * x[n-k], history before the run is zero
  function automatic fir_pkg::sample_t model_out(input int n);
    fir_pkg::sample_t y;
    y = '0;
    for (int k = 0; k < clen; k++) begin
      if (n - k >= 0) begin
        y = y + fir_pkg::sample_t'(taps[k] * xs[n - k]);
      end
    end
    return y;
  endfunction

  task automatic step();
    @(posedge axis_clk);
    #1;
  endtask

  task automatic check_data(input fir_pkg::data_t got, input fir_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      data_errs++;
      $display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_sample(input fir_pkg::sample_t got, input logic got_last,
                              input fir_pkg::sample_t exp, input logic exp_last,
                              input int n);
    if (got !== exp || got_last !== exp_last) begin
      sample_errs++;
      $display("ERROR %0t: output %0d is 0x%08h last %b, expected 0x%08h last %b",
               $time, n, got, got_last, exp, exp_last);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // awready is registered, so the write lands on the edge after it is seen
  task automatic lite_write(input fir_pkg::addr_t a, input fir_pkg::data_t d);
    awaddr  = a;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready)) step();
    step();
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic lite_read(input fir_pkg::addr_t a, output fir_pkg::data_t d);
    araddr  = a;
    arvalid = 1'b1;
    rready  = 1'b1;
    // arready follows arvalid within the same cycle
    #1;
    while (!arready) step();
    step();
    arvalid = 1'b0;
    while (!rvalid) step();
    d = rdata;
    step();
    rready = 1'b0;
  endtask

  task automatic configure();
    fir_pkg::data_t d;
    clen = rand_range(1, tap_num);
    if (clen == prev_clen) begin
      clen = (clen % tap_num) + 1;
    end
    dlen = rand_range(5, max_dlen);
    for (int k = 0; k < tap_num; k++) begin
      taps[k] = next_word();
      lite_write(fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * k), taps[k]);
    end
    lite_write(fir_pkg::ADDR_DATA_LEN, fir_pkg::data_t'(dlen));
    lite_write(fir_pkg::ADDR_COEF_LEN, fir_pkg::data_t'(clen));
    lite_read(fir_pkg::ADDR_DATA_LEN, d);
    check_data(d, fir_pkg::data_t'(dlen), "data_length");
    lite_read(fir_pkg::ADDR_COEF_LEN, d);
    check_data(d, fir_pkg::data_t'(clen), "coef_length");
    for (int k = 0; k < tap_num; k++) begin
      lite_read(fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * k), d);
      check_data(d, taps[k], "tap readback");
    end
    check_flag(ss_tready, 1'b0, "ss_tready before start");
    check_flag(sm_tvalid, 1'b0, "sm_tvalid before start");
  endtask

  task automatic run_once(input logic busy_checks);
    fir_pkg::data_t   d;
    fir_pkg::sample_t got;
    logic             got_last;
    lite_write(fir_pkg::ADDR_AP_CTRL, 32'd1);
    if (busy_checks) begin
      lite_read(fir_pkg::ADDR_AP_CTRL, d);
      check_data(d, fir_pkg::data_t'(fir_pkg::AP_START), "ap_ctrl while running");
      lite_read(fir_pkg::ADDR_TAP_BASE + 12'h004, d);
      check_data(d, fir_pkg::READ_BUSY, "tap 1 while running");
      // must be dropped, the outputs below still use the old tap
      lite_write(fir_pkg::ADDR_TAP_BASE + 12'h004, ~taps[1]);
    end
    for (int n = 0; n < dlen; n++) begin
      xs[n] = next_word();
      repeat (rand_range(0, 3)) step();
      ss_tdata  = xs[n];
      ss_tlast  = (n == dlen - 1);
      ss_tvalid = 1'b1;
      while (!ss_tready) step();
      step();
      ss_tvalid = 1'b0;
      ss_tlast  = 1'b0;
      while (!sm_tvalid) step();
      repeat (rand_range(0, 3)) begin
        step();
        check_flag(ss_tready, 1'b0, "ss_tready while output stalled");
      end
      sm_tready = 1'b1;
      got       = sm_tdata;
      got_last  = sm_tlast;
      step();
      sm_tready = 1'b0;
      check_sample(got, got_last, model_out(n), n == dlen - 1, n);
    end
    repeat (3) begin
      step();
      check_flag(ss_tready, 1'b0, "ss_tready after last beat");
      check_flag(sm_tvalid, 1'b0, "sm_tvalid after last output");
    end
    lite_read(fir_pkg::ADDR_AP_CTRL, d);
    check_data(d, fir_pkg::data_t'(fir_pkg::AP_DONE), "ap_ctrl after run");
    lite_read(fir_pkg::ADDR_AP_CTRL, d);
    check_data(d, fir_pkg::data_t'(fir_pkg::AP_IDLE), "ap_ctrl after done read");
    check_flag(ss_tready, 1'b0, "ss_tready back in idle");
    if (busy_checks) begin
      lite_read(fir_pkg::ADDR_TAP_BASE + 12'h004, d);
      check_data(d, taps[1], "tap 1 after ignored write");
    end
  endtask

  initial begin
    fir_pkg::data_t d;
    seed        = 32'h302d;
    data_errs   = 0;
    sample_errs = 0;
    flag_errs   = 0;
    prev_clen   = 0;
    axis_rst_n  = 1'b0;
    awvalid     = 1'b0;
    wvalid      = 1'b0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    awaddr      = '0;
    araddr      = '0;
    wdata       = '0;
    ss_tvalid   = 1'b0;
    ss_tlast    = 1'b0;
    ss_tdata    = '0;
    sm_tready   = 1'b0;
    repeat (10) @(posedge axis_clk);
    #1;
    axis_rst_n = 1'b1;
    step();
    check_flag(awready, 1'b0, "awready after reset");
    check_flag(wready, 1'b0, "wready after reset");
    check_flag(arready, 1'b0, "arready after reset");
    check_flag(rvalid, 1'b0, "rvalid after reset");
    check_flag(ss_tready, 1'b0, "ss_tready after reset");
    check_flag(sm_tvalid, 1'b0, "sm_tvalid after reset");
    lite_read(fir_pkg::ADDR_AP_CTRL, d);
    check_data(d, fir_pkg::data_t'(fir_pkg::AP_IDLE), "ap_ctrl after reset");
    for (int run = 0; run < num_runs; run++) begin
      configure();
      run_once(run == 1);
      prev_clen = clen;
    end
    $display("errors: %0d register, %0d sample, %0d flag", data_errs, sample_errs, flag_errs);
    if (data_errs + sample_errs + flag_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge axis_clk);
      cycles++;
    end
    $display("timeout: the test did not finish within %0d clock cycles", max_cycles);
    $display("errors: %0d register, %0d sample, %0d flag", data_errs, sample_errs, flag_errs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: fir.f
fir_pkg.sv
fir_ram.sv
fir_axil_slave.sv
fir_regs.sv
fir_engine.sv
fir.sv
tb_fir.sv

// File: run.sh
#!/bin/sh
# compile and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_fir -f fir.f -o tb_fir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi
out=$(./obj_dir/tb_fir)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
